// ==== Bender.yml ====
package:
  name: word_game

sources:
  # RTL in compile order, package first
  - files:
      - verilog/wordGamePkg.sv
      - verilog/wordLoader.sv
      - verilog/guessCapture.sv
      - verilog/gameLogic.sv
      - verilog/lampDriver.sv
      - verilog/wordGameTop.sv

  # self-checking testbench, top module wordGameTb
  - target: test
    files:
      - dv/wordGameTb.sv

// ==== dv/wordGameTb.sv ====
/*
 * Self-checking testbench for the word-guessing game top level.
 * Pulses are sampled at the fixed wordLen+2 latency. Lamp checks assume that
 * successive guesses are spaced further apart than holdCycles.
 */
`timescale 1ns/1ps
`default_nettype none

module wordGameTb;
    import wordGamePkg::*;

    localparam int wordLen         = 5;
    localparam int maxMistakes     = 6;
    localparam int holdCycles      = 8;
    localparam int clkPeriod       = 4;
    localparam int resetCycles     = 8;
    localparam int randomGames     = 4;
    localparam int numGames        = randomGames + 2;
    localparam int attemptsPerGame = 40;
    localparam int guessesPerGame  = 48;            // budget, with room for loading
    localparam int timeoutNs =
        (numGames * guessesPerGame * (wordLen + 10) + resetCycles) * clkPeriod;
    localparam int cntW = $clog2(maxMistakes + 1);

    typedef logic [0:wordLen-1][7:0] word_t;        // element 0 is position 0, the msb

    typedef struct packed {
        logic               accepted;
        logic               hit;
        logic [wordLen-1:0] revealed;
    } guessResult_t;

    typedef struct packed {
        int                 checkCycle;
        logic               accepted;
        logic               hit;
        logic [wordLen-1:0] revealed;
        logic [cntW-1:0]    count;
        gameState_t         state;
        lamps_t             lamps;
    } expected_t;

    logic               clk;
    logic               nRst;
    logic               newGame;
    logic               start;
    letter_t            hostLetter;
    logic               hostStrobe;
    letter_t            playerLetter;
    logic               playerStrobe;
    logic               wordReady;
    gameStatus_t        status;
    gameState_t         state;
    logic [wordLen-1:0] revealed;
    logic [cntW-1:0]    mistakeCount;
    lamps_t             lamps;

    // reference model state
    word_t              secret;
    logic [25:0]        tried;
    logic [wordLen-1:0] expRevealed;
    logic [cntW-1:0]    expCount;
    gameState_t         expState;
    logic [31:0]        rngState = 32'hf827;
    expected_t          expGuess;
    logic               checkPending = 1'b0;
    int                 cycleCnt = 0;

    wordGameTop #(
        .wordLen(wordLen), .maxMistakes(maxMistakes), .holdCycles(holdCycles)
    ) u_dut (
        .clk(clk), .nRst(nRst), .newGame(newGame), .start(start),
        .hostLetter(hostLetter), .hostStrobe(hostStrobe),
        .playerLetter(playerLetter), .playerStrobe(playerStrobe),
        .wordReady(wordReady), .status(status), .state(state),
        .revealed(revealed), .mistakeCount(mistakeCount), .lamps(lamps)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) cycleCnt <= cycleCnt + 1;

    task automatic checkEq(input logic [63:0] got, input logic [63:0] expv, input string what);
        if (got !== expv) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, expv);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] seed);
        logic [31:0] x;
        x = seed;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // a guess counts only in an open game, for a fresh letter 'a'..'z'
    function automatic guessResult_t refGuess(input word_t w, input logic [25:0] triedSet,
                                              input logic [wordLen-1:0] rev, input logic open,
                                              input letter_t l);
        guessResult_t r;
        int i;
        r.accepted = 1'b0;
        r.hit      = 1'b0;
        r.revealed = rev;
        if (open && l >= 8'h61 && l <= 8'h7a) r.accepted = !triedSet[l - 8'h61];
        if (r.accepted) begin
            for (i = 0; i < wordLen; i++) begin
                if (w[i] == l) begin
                    r.revealed[i] = 1'b1;
                    r.hit         = 1'b1;
                end
            end
        end
        return r;
    endfunction

    function automatic lamps_t lampsFor(input gameState_t st, input logic acc, input logic hit);
        lamps_t l;
        l.green = (st == WON) || (st != LOST && acc && hit);
        l.red   = (st == LOST) || (st != WON && acc && !hit);
        return l;
    endfunction

    // sample everything at the falling edge, away from the drive edge
    initial begin
        logic pulseDue;
        forever begin
            @(negedge clk);
            if (nRst) begin
                pulseDue = checkPending && expGuess.accepted &&
                           (cycleCnt == expGuess.checkCycle - 1);
                checkEq(status.hit, pulseDue && expGuess.hit, "hit pulse");
                checkEq(status.mistake, pulseDue && !expGuess.hit, "mistake pulse");
                if (pulseDue) checkEq(status.busy, 1'b1, "busy in JUDGE");
                if (checkPending && cycleCnt == expGuess.checkCycle) begin
                    checkEq(state, expGuess.state, "state after guess");
                    checkEq(revealed, expGuess.revealed, "revealed");
                    checkEq(mistakeCount, expGuess.count, "mistakeCount");
                    checkEq(lamps, expGuess.lamps, "lamps");
                    checkEq(status.over, expGuess.state == WON || expGuess.state == LOST,
                            "over");
                    checkEq(status.gameRdy, 1'b1, "gameRdy after guess");
                    checkPending = 1'b0;
                end
            end
        end
    end

    task automatic loadWord(input word_t w);
        int i;
        secret      = w;
        tried       = '0;
        expRevealed = '0;
        expCount    = '0;
        expState    = IDLE;
        @(posedge clk);
        newGame <= 1'b1;
        @(posedge clk);
        newGame <= 1'b0;
        @(negedge clk);
        checkEq(state, SET, "state after newGame");
        checkEq(wordReady, 1'b0, "wordReady after newGame");
        checkEq(revealed, '0, "revealed after newGame");
        checkEq(mistakeCount, '0, "mistakeCount after newGame");
        checkEq(status.over, 1'b0, "over after newGame");
        checkEq(status.gameRdy, 1'b1, "gameRdy in SET");
        for (i = 0; i < wordLen; i++) begin
            @(posedge clk);
            hostLetter <= w[i];
            hostStrobe <= 1'b1;
            @(negedge clk);
            checkEq(wordReady, 1'b0, "wordReady before last letter");
        end
        @(posedge clk);
        hostLetter <= "q";                          // extra strobe, must not shift in
        @(negedge clk);
        checkEq(wordReady, 1'b1, "wordReady after last letter");
        checkEq(status.gameRdy, 1'b1, "gameRdy with word loaded");
        @(posedge clk);
        hostStrobe <= 1'b0;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        checkEq(state, IDLE, "state after start");
        checkEq(wordReady, 1'b1, "wordReady held");
    endtask

    task automatic playGuess(input letter_t l, input logic poke, input letter_t pokeLetter);
        guessResult_t res;
        int c;
        @(posedge clk);
        c   = cycleCnt;
        res = refGuess(secret, tried, expRevealed, expState == IDLE, l);
        if (res.accepted) begin
            tried[l - 8'h61] = 1'b1;
            expRevealed      = res.revealed;
            if (!res.hit) expCount = expCount + 1'b1;
            if (&expRevealed) expState = WON;
            else if (expCount == maxMistakes) expState = LOST;
        end
        expGuess.checkCycle = c + wordLen + 4;      // pulse one cycle earlier
        expGuess.accepted   = res.accepted;
        expGuess.hit        = res.hit;
        expGuess.revealed   = expRevealed;
        expGuess.count      = expCount;
        expGuess.state      = expState;
        expGuess.lamps      = lampsFor(expState, res.accepted, res.hit);
        checkPending        = 1'b1;
        playerLetter <= l;
        playerStrobe <= 1'b1;
        @(posedge clk);
        playerStrobe <= 1'b0;
        if (poke && res.accepted) begin           // lands while the scan runs
            @(posedge clk);
            playerLetter <= pokeLetter;
            playerStrobe <= 1'b1;
            @(posedge clk);
            playerStrobe <= 1'b0;
        end
        wait (!checkPending);
    endtask

    initial begin
        #(timeoutNs);
        $display("watchdog expired after %0d ns with the game still running", timeoutNs);
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        int g;
        int n;
        int k;
        int i;
        logic [31:0] r;
        letter_t guess;
        word_t w;
        nRst         = 1'b0;
        newGame      = 1'b0;
        start        = 1'b0;
        hostLetter   = '0;
        hostStrobe   = 1'b0;
        playerLetter = '0;
        playerStrobe = 1'b0;
        repeat (resetCycles) @(posedge clk);
        nRst <= 1'b1;
        @(negedge clk);
        checkEq(state, SET, "state after reset");
        checkEq(revealed, '0, "revealed after reset");
        checkEq(status, 5'b10000, "status after reset");
        checkEq(lamps, '0, "lamps after reset");
        checkEq(wordReady, 1'b0, "wordReady after reset");

        // game one ends in WON, with repeats, bad codes and a strobe while busy
        loadWord("level");
        playGuess("e", 1'b0, "a");
        checkEq(revealed, 5'b01010, "both e positions");
        for (k = 1; k <= holdCycles; k++) begin
            @(negedge clk);
            checkEq(lamps.green, k < holdCycles, "green flash length");
        end
        playGuess("e", 1'b0, "a");
        playGuess(8'h41, 1'b0, "a");
        playGuess("x", 1'b1, "v");
        playGuess("v", 1'b0, "a");
        playGuess("l", 1'b0, "a");
        checkEq(state, WON, "game one won");
        playGuess("z", 1'b0, "a");

        // game two ends in LOST, and e must be fresh again
        loadWord("apple");
        playGuess("e", 1'b0, "a");
        playGuess("b", 1'b0, "a");
        playGuess("c", 1'b0, "a");
        playGuess("d", 1'b0, "a");
        playGuess("f", 1'b0, "a");
        playGuess("g", 1'b0, "a");
        playGuess("h", 1'b0, "a");
        checkEq(state, LOST, "game two lost");
        playGuess("a", 1'b0, "a");

        // random words from a..h so letters repeat, guesses from a..l
        for (g = 0; g < randomGames; g++) begin
            for (i = 0; i < wordLen; i++) begin
                rngState = xorshift32(rngState);
                w[i]     = 8'h61 + 8'(rngState % 8);
            end
            loadWord(w);
            for (n = 0; n < attemptsPerGame && expState == IDLE; n++) begin
                rngState = xorshift32(rngState);
                r        = rngState;
                if (r[3:0] == 4'd0) guess = r[4] ? 8'h60 : 8'h7b;
                else guess = 8'h61 + 8'((r >> 5) % 12);
                playGuess(guess, r[9:8] == 2'b00, 8'h61 + 8'((r >> 12) % 26));
            end
            if (expState != IDLE) playGuess("a", 1'b0, "a");
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/wordGamePkg.sv
verilog/wordLoader.sv
verilog/guessCapture.sv
verilog/gameLogic.sv
verilog/lampDriver.sv
verilog/wordGameTop.sv
dv/wordGameTb.sv

// ==== verilog/gameLogic.sv ====
/*
 * Game FSM. A guess is compared against one word position per cycle, so a
 * guess takes wordLen SCAN cycles and one JUDGE cycle. A letter that occurs
 * more than once is revealed at every position by the same guess.
 */
`timescale 1ns/1ps
`default_nettype none

module gameLogic #(
    parameter int wordLen     = 5,
    parameter int maxMistakes = 6
) (
    input  logic                                 clk,
    input  logic                                 nRst,
    input  logic                                 start,
    input  logic                                 newGame,
    input  logic [wordLen*8-1:0]                 word,
    input  logic                                 wordReady,
    input  wordGamePkg::letter_t                 guessLetter,
    input  logic                                 guessValid,
    output logic                                 acceptGuess,
    output wordGamePkg::gameStatus_t             status,
    output wordGamePkg::gameState_t              state,
    output logic [wordLen-1:0]                   revealed,
    output logic [$clog2(maxMistakes+1)-1:0]     mistakeCount
);
    import wordGamePkg::*;

    localparam int cntW = $clog2(maxMistakes + 1);
    localparam int idxW = $clog2(wordLen);

    gameState_t      nextState;
    letter_t         guessReg;                     // letter under test
    letter_t         curLetter;                    // word letter at scanIdx
    logic [idxW-1:0] scanIdx;
    logic            lastPos;
    logic            posMatch;
    logic            anyMatch;                     // some position matched this guess
    logic [cntW-1:0] nextMistakes;

    // position 0 is the msb letter
    assign curLetter    = word[8*(wordLen-1-int'(scanIdx)) +: 8];
    assign lastPos      = (scanIdx == idxW'(wordLen - 1));
    assign posMatch     = (curLetter == guessReg);
    assign nextMistakes = anyMatch ? mistakeCount : mistakeCount + 1'b1;

    // closed for one cycle behind an accepted guess, before SCAN is entered
    assign acceptGuess = (state == IDLE) && !guessValid;

    always_comb begin
        status.gameRdy = (state == SET) || (state == IDLE) || (state == WON) || (state == LOST);
        status.busy    = (state == SCAN) || (state == JUDGE);
        status.hit     = (state == JUDGE) && anyMatch;
        status.mistake = (state == JUDGE) && !anyMatch;
        status.over    = (state == WON) || (state == LOST);
    end

    always_comb begin
        nextState = state;
        case (state)
            SET: begin
                if (start && wordReady) nextState = IDLE;
            end
            IDLE: begin
                if (guessValid) nextState = SCAN;
            end
            SCAN: begin
                if (lastPos) nextState = JUDGE;
            end
            JUDGE: begin
                if (&revealed) begin
                    nextState = WON;
                end else if (nextMistakes == cntW'(maxMistakes)) begin
                    nextState = LOST;
                end else begin
                    nextState = IDLE;
                end
            end
            WON, LOST: begin
                nextState = state;                 // only newGame leaves
            end
            default: begin
                nextState = SET;
            end
        endcase
        if (newGame) nextState = SET;
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state        <= SET;
            scanIdx      <= '0;
            anyMatch     <= 1'b0;
            revealed     <= '0;
            mistakeCount <= '0;
        end else begin
            state <= nextState;
            if (newGame) begin
                scanIdx      <= '0;
                anyMatch     <= 1'b0;
                revealed     <= '0;
                mistakeCount <= '0;
            end else begin
                case (state)
                    IDLE: begin
                        if (guessValid) anyMatch <= 1'b0;
                    end
                    SCAN: begin
                        if (posMatch) begin
                            revealed[scanIdx] <= 1'b1;
                            anyMatch          <= 1'b1;
                        end
                        scanIdx <= lastPos ? '0 : scanIdx + 1'b1;
                    end
                    JUDGE: begin
                        mistakeCount <= nextMistakes;  // unchanged on a hit
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && guessValid) guessReg <= guessLetter;
    end

    // a fresh letter can only match positions that were still hidden
    hitRevealsNew: assert property (
        @(posedge clk) disable iff (!nRst)
        (state == JUDGE) |-> (status.hit == (revealed != $past(revealed, wordLen)))
    ) else $error("hit pulse disagrees with the newly revealed positions");

    mistakeBound: assert property (
        @(posedge clk) disable iff (!nRst)
        mistakeCount <= cntW'(maxMistakes)
    ) else $error("mistake count above maxMistakes");

    // guessCapture must only forward guesses opened by acceptGuess
    guessOnlyIdle: assert property (
        @(posedge clk) disable iff (!nRst)
        guessValid |-> (state == IDLE)
    ) else $error("guessValid outside IDLE");

endmodule

`default_nettype wire

// ==== verilog/guessCapture.sv ====
/*
 * Guess filter. Drops strobes outside 'a' to 'z', letters already tried in
 * this game, and strobes while acceptGuess is low. A dropped strobe leaves no trace.
 */
`timescale 1ns/1ps
`default_nettype none

module guessCapture (
    input  logic                 clk,
    input  logic                 nRst,
    input  logic                 newGame,
    input  wordGamePkg::letter_t playerLetter,
    input  logic                 playerStrobe,
    input  logic                 acceptGuess,
    output wordGamePkg::letter_t guessLetter,
    output logic                 guessValid
);
    import wordGamePkg::*;

    localparam int idxW = $clog2(alphabetSize);

    logic [alphabetSize-1:0] triedMask;            // one bit per letter a..z
    letter_t                 letterOffset;
    logic [idxW-1:0]         letterIdx;
    logic                    inRange;
    logic                    alreadyTried;
    logic                    accept;

    assign inRange      = (playerLetter >= firstLetter) && (playerLetter <= lastLetter);
    assign letterOffset = playerLetter - firstLetter;
    assign letterIdx    = letterOffset[idxW-1:0];
    assign alreadyTried = inRange && triedMask[letterIdx];
    assign accept       = playerStrobe && acceptGuess && inRange && !alreadyTried && !newGame;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            triedMask  <= '0;
            guessValid <= 1'b0;
        end else if (newGame) begin
            triedMask  <= '0;
            guessValid <= 1'b0;
        end else begin
            guessValid <= accept;
            if (accept) triedMask[letterIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) guessLetter <= playerLetter;   // held for gameLogic to latch
    end

    // gameLogic drops acceptGuess while a guess is pending, so pulses stay apart
    guessPulseSingle: assert property (
        @(posedge clk) disable iff (!nRst)
        guessValid |=> !guessValid
    ) else $error("guessValid high in two consecutive cycles");

endmodule

`default_nettype wire

// ==== verilog/lampDriver.sv ====
/*
 * Lamp driver. Each hit or mistake pulse lights its lamp for holdCycles
 * cycles, restarting on a new pulse. WON and LOST override the flashes.
 */
`timescale 1ns/1ps
`default_nettype none

module lampDriver #(
    parameter int holdCycles = 8
) (
    input  logic                     clk,
    input  logic                     nRst,
    input  wordGamePkg::gameStatus_t status,
    input  wordGamePkg::gameState_t  state,
    output wordGamePkg::lamps_t      lamps
);
    import wordGamePkg::*;

    localparam int cntW = $clog2(holdCycles + 1);

    logic [cntW-1:0] greenCnt;                     // cycles of green flash left
    logic [cntW-1:0] redCnt;                       // cycles of red flash left

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            greenCnt <= '0;
            redCnt   <= '0;
        end else begin
            if (status.hit) greenCnt <= cntW'(holdCycles);
            else if (greenCnt != '0) greenCnt <= greenCnt - 1'b1;

            if (status.mistake) redCnt <= cntW'(holdCycles);
            else if (redCnt != '0) redCnt <= redCnt - 1'b1;
        end
    end

    always_comb begin
        case (state)
            WON: begin
                lamps.green = 1'b1;
                lamps.red   = 1'b0;
            end
            LOST: begin
                lamps.green = 1'b0;
                lamps.red   = 1'b1;
            end
            default: begin
                lamps.green = (greenCnt != '0);
                lamps.red   = (redCnt != '0);
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/wordGamePkg.sv ====
/*
 * Shared types for the word-guessing game controller.
 * Letters are plain 8-bit ASCII codes. Only 'a' to 'z' take part in a game.
 * Word length, mistake limit and lamp hold time are module parameters, not set here.
 */
`default_nettype none

package wordGamePkg;

    typedef logic [7:0] letter_t;                  // one ascii letter code

    localparam letter_t firstLetter = 8'h61;       // 'a'
    localparam letter_t lastLetter  = 8'h7a;       // 'z'
    localparam int      alphabetSize = 26;         // width of the tried-letter mask

    // controller states
    typedef enum logic [2:0] {
        SET   = 3'd0,                              // host is loading the word
        IDLE  = 3'd1,                              // waiting for a guess
        SCAN  = 3'd2,                              // one position per cycle
        JUDGE = 3'd3,                              // hit or miss decided here
        WON   = 3'd4,
        LOST  = 3'd5
    } gameState_t;

    // status seen by the lamps and by the host
    typedef struct packed {
        logic gameRdy;                             // level, SET / IDLE / WON / LOST
        logic busy;                                // level, SCAN / JUDGE
        logic hit;                                 // one-cycle pulse in JUDGE
        logic mistake;                             // one-cycle pulse in JUDGE
        logic over;                                // level, WON / LOST
    } gameStatus_t;

    typedef struct packed {
        logic red;
        logic green;
    } lamps_t;

endpackage

`default_nettype wire

// ==== verilog/wordGameTop.sv ====
/*
 * Word-guessing game top level. No handshake on any input: guesses that
 * arrive while a comparison runs are lost. A guess strobe reaches its hit
 * or mistake pulse after wordLen+2 cycles.
 */
`timescale 1ns/1ps
`default_nettype none

module wordGameTop #(
    parameter int wordLen     = 5,
    parameter int maxMistakes = 6,
    parameter int holdCycles  = 8
) (
    input  logic                             clk,
    input  logic                             nRst,
    input  logic                             newGame,
    input  logic                             start,
    input  wordGamePkg::letter_t             hostLetter,
    input  logic                             hostStrobe,
    input  wordGamePkg::letter_t             playerLetter,
    input  logic                             playerStrobe,
    output logic                             wordReady,
    output wordGamePkg::gameStatus_t         status,
    output wordGamePkg::gameState_t          state,
    output logic [wordLen-1:0]               revealed,
    output logic [$clog2(maxMistakes+1)-1:0] mistakeCount,
    output wordGamePkg::lamps_t              lamps
);
    import wordGamePkg::*;

    logic [wordLen*8-1:0] word;
    logic                 acceptGuess;
    letter_t              guessLetter;
    logic                 guessValid;

    wordLoader #(.wordLen(wordLen)) u_wordLoader (
        .clk(clk), .nRst(nRst), .newGame(newGame),
        .hostLetter(hostLetter), .hostStrobe(hostStrobe),
        .word(word), .wordReady(wordReady)
    );

    guessCapture u_guessCapture (
        .clk(clk), .nRst(nRst), .newGame(newGame),
        .playerLetter(playerLetter), .playerStrobe(playerStrobe),
        .acceptGuess(acceptGuess),
        .guessLetter(guessLetter), .guessValid(guessValid)
    );

    gameLogic #(.wordLen(wordLen), .maxMistakes(maxMistakes)) u_gameLogic (
        .clk(clk), .nRst(nRst), .start(start), .newGame(newGame),
        .word(word), .wordReady(wordReady),
        .guessLetter(guessLetter), .guessValid(guessValid),
        .acceptGuess(acceptGuess), .status(status), .state(state),
        .revealed(revealed), .mistakeCount(mistakeCount)
    );

    lampDriver #(.holdCycles(holdCycles)) u_lampDriver (
        .clk(clk), .nRst(nRst),
        .status(status), .state(state),
        .lamps(lamps)
    );

endmodule

`default_nettype wire

// ==== verilog/wordLoader.sv ====
/*
 * Secret word shift register. The first letter loaded lands at position 0,
 * the most significant byte. Needs wordLen of 2 or more. Strobes after the
 * word is complete are ignored until newGame clears it.
 */
`timescale 1ns/1ps
`default_nettype none

module wordLoader #(
    parameter int wordLen = 5
) (
    input  logic                     clk,
    input  logic                     nRst,
    input  logic                     newGame,
    input  wordGamePkg::letter_t     hostLetter,
    input  logic                     hostStrobe,
    output logic [wordLen*8-1:0]     word,
    output logic                     wordReady
);

    localparam int cntW = $clog2(wordLen + 1);

    logic [cntW-1:0] loadCount;                    // letters shifted in so far
    logic            shiftEn;

    assign shiftEn   = hostStrobe && !wordReady && !newGame;
    assign wordReady = (loadCount == cntW'(wordLen));

    // letter counter, the only control state here
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            loadCount <= '0;
        end else if (newGame) begin
            loadCount <= '0;
        end else if (shiftEn) begin
            loadCount <= loadCount + 1'b1;
        end
    end

    // older letters move toward the msb as new ones enter at the bottom
    always_ff @(posedge clk) begin
        if (newGame) begin
            word <= '0;
        end else if (shiftEn) begin
            word <= {word[wordLen*8-9:0], hostLetter};
        end
    end

    // the count stops at wordLen, so wordReady never drops without newGame
    loadCountBound: assert property (
        @(posedge clk) disable iff (!nRst)
        loadCount <= cntW'(wordLen)
    ) else $error("word loader count passed wordLen");

endmodule

`default_nettype wire
